/* verilog/core_defines.svh */
// core_defines: widths, register count, reset pc and memory sizes for the rv32i core
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// data path and address width
`define XLEN 32

// architectural integer registers, x0 included
`define REG_COUNT 32

// first instruction address after reset
`define START_PC 32'h0000_0000

// memory model depths in 32-bit words
`define IMEM_WORDS 1024
`define DMEM_WORDS 1024

`endif

/* verilog/rv_isa_pkg.sv */
// rv_isa_pkg: rv32i opcode, alu operation, branch condition and access size encodings
package rv_isa_pkg;

    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111,
        OP_HALT   = 7'h7F        // core specific, stops the pipeline
    } opcode_e;

    // low three bits follow funct3, bit 3 follows funct7[5]
    typedef enum logic [3:0] {
        ADD      = 4'h0,
        SLL      = 4'h1,
        SLT      = 4'h2,
        SLTU     = 4'h3,
        XOR      = 4'h4,
        SRL      = 4'h5,
        OR       = 4'h6,
        AND      = 4'h7,
        SUB      = 4'h8,
        SRA      = 4'hD,
        PASS_IMM = 4'hF          // lui, auipc and link value
    } alu_op_e;

    typedef enum logic [2:0] {
        NONE = 3'd0,
        EQ   = 3'd1,
        NE   = 3'd2,
        LT   = 3'd3,
        GE   = 3'd4,
        LTU  = 3'd5,
        GEU  = 3'd6,
        JUMP = 3'd7              // jal and jalr, always taken
    } br_cond_e;

    typedef enum logic [1:0] {
        BYTE = 2'd0,             // same as funct3[1:0]
        HALF = 2'd1,
        WORD = 2'd2
    } mem_size_e;

endpackage

/* verilog/core_pipe_pkg.sv */
// core_pipe_pkg: packets passed between the pipeline stages and on the core ports
`include "core_defines.svh"

package core_pipe_pkg;
    import rv_isa_pkg::*;

    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        reg_idx_t         rs1;
        reg_idx_t         rs2;
        reg_idx_t         rd;
        logic             reg_we;
        alu_op_e          alu_op;
        br_cond_e         br_cond;
        mem_size_e        mem_size;
        logic             load;
        logic             store;
        logic             load_unsigned;
        logic             use_imm;       // operand b is the immediate
        logic             jalr;
        logic             halt;
        logic [`XLEN-1:0] rs1_val;       // read in decode, may be stale
        logic [`XLEN-1:0] rs2_val;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] alu_imm;       // lui / auipc / link value
    } dec_pkt_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        reg_idx_t         rd;
        logic             reg_we;
        logic [`XLEN-1:0] alu_res;
        logic             load;
        mem_size_e        mem_size;
        logic             load_unsigned;
        logic [1:0]       byte_off;
        logic             halt;
    } exe_pkt_t;

    typedef struct packed {
        logic             valid;
        reg_idx_t         rd;
        logic [`XLEN-1:0] data;
    } wb_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
        logic [3:0]       mask;          // byte write enables
        logic             re;
    } dmem_req_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
    } retire_t;

endpackage

/* verilog/stage_reg.sv */
// stage_reg: one pipeline slot with valid bit, flush and freeze for any payload type
`timescale 1ns/10ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     CLK,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     freeze,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;          // wrong path slot
        end else if (!freeze) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!freeze) begin
            out_data <= in_data;        // payload only, valid bit qualifies it
        end
    end

endmodule

/* verilog/inst_decode.sv */
// inst_decode: rv32i decoder, immediate generation and register file with write-through
`timescale 1ns/10ps
`include "core_defines.svh"

module inst_decode
    import rv_isa_pkg::*, core_pipe_pkg::*;
(
    input  logic       CLK,
    input  logic       rst_n,
    input  logic       in_valid,
    input  fetch_pkt_t in_pkt,
    input  wb_t        wb,
    output dec_pkt_t   out_pkt
);

    logic [31:0]      inst;
    opcode_e          opcode;
    logic [2:0]       funct3;
    reg_idx_t         rs1;
    reg_idx_t         rs2;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] regs [`REG_COUNT];

    assign inst   = in_pkt.inst;
    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // write at the end of the result cycle
    always_ff @(posedge CLK) begin
        if (rst_n && wb.valid) begin
            regs[wb.rd] <= wb.data;     // wb.valid never set for x0
        end
    end

    // x0 reads zero, a same-cycle write is seen through
    assign rs1_val = (rs1 == '0) ? '0 : (wb.valid && wb.rd == rs1) ? wb.data : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : (wb.valid && wb.rd == rs2) ? wb.data : regs[rs2];

    always_comb begin
        out_pkt               = '0;
        out_pkt.pc            = in_pkt.pc;
        out_pkt.rs1           = rs1;
        out_pkt.rs2           = rs2;
        out_pkt.rd            = inst[11:7];
        out_pkt.alu_op        = ADD;
        out_pkt.br_cond       = NONE;
        out_pkt.mem_size      = mem_size_e'(funct3[1:0]);
        out_pkt.load_unsigned = funct3[2];
        out_pkt.rs1_val       = rs1_val;
        out_pkt.rs2_val       = rs2_val;
        case (opcode)
            OP_LUI: begin
                out_pkt.reg_we  = 1'b1;
                out_pkt.alu_op  = PASS_IMM;
                out_pkt.imm     = imm_u;
                out_pkt.alu_imm = imm_u;
            end
            OP_AUIPC: begin
                out_pkt.reg_we  = 1'b1;
                out_pkt.alu_op  = PASS_IMM;
                out_pkt.imm     = imm_u;
                out_pkt.alu_imm = in_pkt.pc + imm_u;
            end
            OP_JAL, OP_JALR: begin
                out_pkt.reg_we  = 1'b1;
                out_pkt.alu_op  = PASS_IMM;
                out_pkt.br_cond = JUMP;
                out_pkt.jalr    = (opcode == OP_JALR);
                out_pkt.imm     = (opcode == OP_JALR) ? imm_i : imm_j;
                out_pkt.alu_imm = in_pkt.pc + 'd4;     // link value
            end
            OP_BRANCH: begin
                out_pkt.imm = imm_b;
                case (funct3)
                    3'b000:  out_pkt.br_cond = EQ;
                    3'b001:  out_pkt.br_cond = NE;
                    3'b100:  out_pkt.br_cond = LT;
                    3'b101:  out_pkt.br_cond = GE;
                    3'b110:  out_pkt.br_cond = LTU;
                    3'b111:  out_pkt.br_cond = GEU;
                    default: out_pkt.br_cond = NONE;
                endcase
            end
            OP_LOAD: begin
                out_pkt.reg_we  = 1'b1;
                out_pkt.load    = 1'b1;
                out_pkt.use_imm = 1'b1;
                out_pkt.imm     = imm_i;
            end
            OP_STORE: begin
                out_pkt.store   = 1'b1;
                out_pkt.use_imm = 1'b1;
                out_pkt.imm     = imm_s;
            end
            OP_IMM: begin
                out_pkt.reg_we  = 1'b1;
                out_pkt.use_imm = 1'b1;
                out_pkt.imm     = imm_i;
                // funct7[5] only selects srai, elsewhere it is immediate bits
                out_pkt.alu_op  = alu_op_e'({(funct3 == 3'b101) & inst[30], funct3});
            end
            OP_REG: begin
                out_pkt.reg_we = 1'b1;
                out_pkt.alu_op = alu_op_e'({inst[30], funct3});
            end
            OP_HALT: out_pkt.halt = 1'b1;
            default: ;
        endcase
        if (!in_valid) begin            // bubble carries no side effects
            out_pkt.reg_we  = 1'b0;
            out_pkt.load    = 1'b0;
            out_pkt.store   = 1'b0;
            out_pkt.halt    = 1'b0;
            out_pkt.br_cond = NONE;
        end
    end

endmodule

/* verilog/inst_execute.sv */
// inst_execute: operand forwarding, alu, branch resolution and data memory issue
`timescale 1ns/10ps
`include "core_defines.svh"

module inst_execute
    import rv_isa_pkg::*, core_pipe_pkg::*;
(
    input  logic      in_valid,
    input  dec_pkt_t  in_pkt,
    input  wb_t       fwd,
    output exe_pkt_t  out_pkt,
    output dmem_req_t dmem_req,
    output redirect_t redirect
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] mem_addr;
    logic [`XLEN-1:0] jump_target;
    logic [`XLEN-1:0] store_data;
    logic [3:0]       base_mask;
    logic [1:0]       mask_shift;
    logic             taken;
    logic             cmp_eq;
    logic             cmp_lt;
    logic             cmp_ltu;

    // result stage value wins over the copy read in decode
    assign op_a    = (fwd.valid && fwd.rd == in_pkt.rs1) ? fwd.data : in_pkt.rs1_val;
    assign rs2_val = (fwd.valid && fwd.rd == in_pkt.rs2) ? fwd.data : in_pkt.rs2_val;
    assign op_b    = in_pkt.use_imm ? in_pkt.imm : rs2_val;

    always_comb begin
        case (in_pkt.alu_op)
            ADD:      alu_res = op_a + op_b;
            SUB:      alu_res = op_a - op_b;
            SLL:      alu_res = op_a << op_b[4:0];
            SLT:      alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            SLTU:     alu_res = {{(`XLEN-1){1'b0}}, op_a < op_b};
            XOR:      alu_res = op_a ^ op_b;
            SRL:      alu_res = op_a >> op_b[4:0];
            SRA:      alu_res = $signed(op_a) >>> op_b[4:0];
            OR:       alu_res = op_a | op_b;
            AND:      alu_res = op_a & op_b;
            PASS_IMM: alu_res = in_pkt.alu_imm;
            default:  alu_res = '0;
        endcase
    end

    // branches compare both registers, never the immediate
    assign cmp_eq  = (op_a == rs2_val);
    assign cmp_lt  = ($signed(op_a) < $signed(rs2_val));
    assign cmp_ltu = (op_a < rs2_val);

    always_comb begin
        case (in_pkt.br_cond)
            EQ:      taken = cmp_eq;
            NE:      taken = !cmp_eq;
            LT:      taken = cmp_lt;
            GE:      taken = !cmp_lt;
            LTU:     taken = cmp_ltu;
            GEU:     taken = !cmp_ltu;
            JUMP:    taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign jump_target = in_pkt.jalr ? ((op_a + in_pkt.imm) & ~`XLEN'(1))
                                     : (in_pkt.pc + in_pkt.imm);

    // halt also redirects to itself so nothing younger reaches execute
    assign redirect.valid  = in_valid && (taken || in_pkt.halt);
    assign redirect.target = in_pkt.halt ? in_pkt.pc : jump_target;

    assign mem_addr = op_a + in_pkt.imm;

    always_comb begin
        case (in_pkt.mem_size)
            BYTE: begin
                store_data = {4{rs2_val[7:0]}};
                base_mask  = 4'b0001;
                mask_shift = mem_addr[1:0];
            end
            HALF: begin
                store_data = {2{rs2_val[15:0]}};
                base_mask  = 4'b0011;
                mask_shift = {mem_addr[1], 1'b0};   // halfword lanes only
            end
            default: begin
                store_data = rs2_val;
                base_mask  = 4'b1111;
                mask_shift = 2'b00;
            end
        endcase
    end

    assign dmem_req.addr  = mem_addr;
    assign dmem_req.wdata = store_data;
    assign dmem_req.mask  = (in_valid && in_pkt.store) ? (base_mask << mask_shift) : 4'b0000;
    assign dmem_req.re    = in_valid && in_pkt.load;

    always_comb begin
        out_pkt               = '0;
        out_pkt.pc            = in_pkt.pc;
        out_pkt.rd            = in_pkt.rd;
        out_pkt.reg_we        = in_pkt.reg_we;
        out_pkt.alu_res       = alu_res;
        out_pkt.load          = in_pkt.load;
        out_pkt.mem_size      = in_pkt.mem_size;
        out_pkt.load_unsigned = in_pkt.load_unsigned;
        out_pkt.byte_off      = mem_addr[1:0];      // picks the lane in result
        out_pkt.halt          = in_pkt.halt;
    end

endmodule

/* verilog/inst_result.sv */
// inst_result: load lane extraction, register write-back, retirement and sticky halt
`timescale 1ns/10ps
`include "core_defines.svh"

module inst_result
    import rv_isa_pkg::*, core_pipe_pkg::*;
(
    input  logic             CLK,
    input  logic             rst_n,
    input  logic             in_valid,
    input  exe_pkt_t         in_pkt,
    input  logic [`XLEN-1:0] dmem_rdata,
    output wb_t              wb,
    output retire_t          retire,
    output logic             halt
);

    logic             halt_q;
    logic             live;
    logic [7:0]       byte_val;
    logic [15:0]      half_val;
    logic [`XLEN-1:0] load_val;

    assign live = in_valid && !halt_q;  // frozen slot never retires twice

    assign byte_val = dmem_rdata[{in_pkt.byte_off, 3'b000} +: 8];
    assign half_val = in_pkt.byte_off[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

    always_comb begin
        case (in_pkt.mem_size)
            BYTE:    load_val = {{(`XLEN-8){byte_val[7] & !in_pkt.load_unsigned}}, byte_val};
            HALF:    load_val = {{(`XLEN-16){half_val[15] & !in_pkt.load_unsigned}}, half_val};
            default: load_val = dmem_rdata;
        endcase
    end

    assign wb.valid = live && in_pkt.reg_we && (in_pkt.rd != '0);
    assign wb.rd    = in_pkt.rd;
    assign wb.data  = in_pkt.load ? load_val : in_pkt.alu_res;

    assign retire.valid = live;
    assign retire.pc    = in_pkt.pc;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            halt_q <= 1'b0;
        end else if (live && in_pkt.halt) begin
            halt_q <= 1'b1;             // held until the next reset
        end
    end

    assign halt = halt_q;

endmodule

/* verilog/rv_core.sv */
// rv_core: four-stage rv32i pipeline top with fetch pc, stage registers and stage logic
`timescale 1ns/10ps
`include "core_defines.svh"

module rv_core
    import core_pipe_pkg::*;
(
    input  logic             CLK,
    input  logic             rst_n,
    output logic [`XLEN-1:0] imem_addr,
    input  logic [`XLEN-1:0] imem_data,
    output dmem_req_t        dmem_req,
    input  logic [`XLEN-1:0] dmem_rdata,
    output retire_t          retire,
    output logic             halt
);

    logic [`XLEN-1:0] pc;               // address of the word now on imem_data
    logic [`XLEN-1:0] next_pc;
    logic             fetch_valid;
    fetch_pkt_t       fetch_pkt;
    fetch_pkt_t       fd_pkt;
    logic             fd_valid;
    dec_pkt_t         dec_pkt;
    dec_pkt_t         de_pkt;
    logic             de_valid;
    exe_pkt_t         exe_pkt;
    exe_pkt_t         er_pkt;
    logic             er_valid;
    wb_t              wb;
    redirect_t        redirect;

    assign next_pc   = halt ? pc : redirect.valid ? redirect.target : pc + 'd4;
    assign imem_addr = next_pc;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            pc          <= `START_PC - 'd4;   // first request is START_PC
            fetch_valid <= 1'b0;
        end else begin
            pc          <= next_pc;
            fetch_valid <= 1'b1;
        end
    end

    assign fetch_pkt = '{pc: pc, inst: imem_data};

    stage_reg #(.payload_t(fetch_pkt_t)) u_fetch_reg (
        .CLK, .rst_n, .flush(redirect.valid), .freeze(halt),
        .in_valid(fetch_valid), .in_data(fetch_pkt),
        .out_valid(fd_valid), .out_data(fd_pkt)
    );

    inst_decode u_decode (
        .CLK, .rst_n, .in_valid(fd_valid), .in_pkt(fd_pkt), .wb, .out_pkt(dec_pkt)
    );

    stage_reg #(.payload_t(dec_pkt_t)) u_dec_reg (
        .CLK, .rst_n, .flush(redirect.valid), .freeze(halt),
        .in_valid(fd_valid), .in_data(dec_pkt),
        .out_valid(de_valid), .out_data(de_pkt)
    );

    inst_execute u_execute (
        .in_valid(de_valid), .in_pkt(de_pkt), .fwd(wb),
        .out_pkt(exe_pkt), .dmem_req, .redirect
    );

    stage_reg #(.payload_t(exe_pkt_t)) u_exe_reg (
        .CLK, .rst_n, .flush(1'b0), .freeze(halt),   // redirecting op itself proceeds
        .in_valid(de_valid), .in_data(exe_pkt),
        .out_valid(er_valid), .out_data(er_pkt)
    );

    inst_result u_result (
        .CLK, .rst_n, .in_valid(er_valid), .in_pkt(er_pkt), .dmem_rdata,
        .wb, .retire, .halt
    );

endmodule

/* sim/rv_core_assert.sv */
// rv_core_assert: concurrent checks on the halt output and data memory port of the core
`timescale 1ns/10ps

module rv_core_assert
    import core_pipe_pkg::*;
(
    input logic      CLK,
    input logic      rst_n,
    input dmem_req_t dmem_req,
    input logic      halt
);

    // sticky until the next reset
    halt_sticky: assert property (@(posedge CLK) disable iff (!rst_n) $past(halt) |-> halt)
        else $error("halt fell while reset was released");

    mask_legal: assert property (@(posedge CLK) disable iff (!rst_n)
        dmem_req.mask inside {4'h0, 4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hC, 4'hF})
        else $error("store mask %h is not a legal byte, half or word lane", dmem_req.mask);

    no_store_halted: assert property (@(posedge CLK) disable iff (!rst_n)
        halt |-> dmem_req.mask == 4'h0)
        else $error("store issued while the core is halted");

endmodule

bind rv_core rv_core_assert u_core_assert (
    .CLK, .rst_n, .dmem_req, .halt
);

/* sim/tb_rv_core.sv */
// tb_rv_core: runs the programs of the cases file on the core and checks every store
`timescale 1ns/10ps
`include "core_defines.svh"

module tb_rv_core
    import core_pipe_pkg::*;
;

    localparam int CASE_WORDS = 512;
    localparam int IMEM_AW    = $clog2(`IMEM_WORDS);
    localparam int DMEM_AW    = $clog2(`DMEM_WORDS);

    logic             CLK = 1'b0;
    logic             rst_n;
    logic [`XLEN-1:0] imem_addr;
    logic [`XLEN-1:0] imem_data = '0;
    logic [`XLEN-1:0] dmem_rdata = '0;
    dmem_req_t        dmem_req;
    retire_t          retire;
    logic             halt;

    logic [31:0]      imem [`IMEM_WORDS];
    logic [31:0]      dmem [`DMEM_WORDS];
    logic [31:0]      case_words [CASE_WORDS];
    logic [31:0]      imem_addr_q = '0;
    logic [31:0]      dmem_raddr_q = '0;
    logic             dmem_re_q = 1'b0;

    logic [31:0]      exp_addr [$];     // expected stores, program order
    logic [31:0]      exp_data [$];
    logic [3:0]       exp_mask [$];
    logic [31:0]      halt_pc;          // address of the halt word
    logic [31:0]      last_retire_pc;
    int               retire_count;
    int               cycle_count;
    int               cycle_limit;

    rv_core u_rv_core (
        .CLK, .rst_n, .imem_addr, .imem_data, .dmem_req, .dmem_rdata, .retire, .halt
    );

    always #50 CLK = ~CLK;

    // synchronous memories, address taken at the rising edge
    always @(posedge CLK) begin
        imem_addr_q  <= imem_addr;
        dmem_re_q    <= dmem_req.re;
        dmem_raddr_q <= dmem_req.addr;
        for (int b = 0; b < 4; b++) begin
            if (dmem_req.mask[b]) begin
                dmem[dmem_req.addr[DMEM_AW+1:2]][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
            end
        end
    end

    // read data shows up on the falling edge of the next cycle
    always @(negedge CLK) begin
        imem_data <= imem[imem_addr_q[IMEM_AW+1:2]];
        if (dmem_re_q) begin
            dmem_rdata <= dmem[dmem_raddr_q[DMEM_AW+1:2]];
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    // one store seen on the port is matched against the next record
    task automatic check_store();
        logic [31:0] a;
        logic [31:0] d;
        logic [3:0]  m;
        if (rst_n && dmem_req.mask != 4'b0000) begin
            assert (exp_addr.size() > 0)
                else fail_run($sformatf("unexpected store to address %h", dmem_req.addr));
            a = exp_addr.pop_front();
            d = exp_data.pop_front();
            m = exp_mask.pop_front();
            assert (dmem_req.addr == a)
                else fail_run($sformatf("mismatch dmem_req.addr: expected %h, got %h",
                                        a, dmem_req.addr));
            assert (dmem_req.wdata == d)
                else fail_run($sformatf("mismatch dmem_req.wdata: expected %h, got %h",
                                        d, dmem_req.wdata));
            assert (dmem_req.mask == m)
                else fail_run($sformatf("mismatch dmem_req.mask: expected %h, got %h",
                                        m, dmem_req.mask));
        end
    endtask

    // first retirement is the reset pc, the last one is kept for the halt check
    task automatic track_retire();
        if (rst_n && retire.valid) begin
            if (retire_count == 0) begin
                assert (retire.pc == `START_PC)
                    else fail_run($sformatf("mismatch retire.pc: expected %h, got %h",
                                            `START_PC, retire.pc));
            end
            last_retire_pc = retire.pc;
            retire_count++;
        end
    endtask

    task automatic step_cycle();
        #25;                            // load data of the falling edge has settled
        check_store();
        track_retire();
        @(negedge CLK);
        cycle_count++;
        assert (cycle_count <= cycle_limit)
            else fail_run("timeout, the core never reached its halt instruction");
    endtask

    initial begin
        int pos;
        int n;
        int s;
        int total;
        rst_n       = 1'b0;
        cycle_count = 0;
        $readmemh("sim/rv_core_cases.txt", case_words);
        pos   = 0;
        total = 0;
        while (case_words[pos] != 0) begin  // sizes only, for the timeout
            total += case_words[pos];
            pos   += 2 + case_words[pos] + 3 * case_words[pos+1];
        end
        cycle_limit = 20 * total;
        pos = 0;
        while (case_words[pos] != 0) begin
            n    = case_words[pos];
            s    = case_words[pos+1];
            pos += 2;
            rst_n = 1'b0;
            for (int i = 0; i < `IMEM_WORDS; i++) begin
                // opcode zero past the program, tagged with the word index
                imem[i] = (i < n) ? case_words[pos+i] : {i[24:0], 7'h00};
            end
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] = 32'h0;
            end
            halt_pc = '1;
            for (int i = n - 1; i >= 0; i--) begin
                if (case_words[pos+i][6:0] == 7'h7F) begin
                    halt_pc = `START_PC + 4 * i;
                end
            end
            pos += n;
            for (int i = 0; i < s; i++) begin
                exp_addr.push_back(case_words[pos]);
                exp_data.push_back(case_words[pos+1]);
                exp_mask.push_back(case_words[pos+2][3:0]);
                pos += 3;
            end
            retire_count   = 0;
            last_retire_pc = '1;
            repeat (4) step_cycle();
            rst_n = 1'b1;
            while (!halt) begin
                step_cycle();
            end
            assert (exp_addr.size() == 0)
                else fail_run($sformatf("halt reached with %0d expected stores missing",
                                        exp_addr.size()));
            assert (last_retire_pc == halt_pc)
                else fail_run($sformatf("mismatch retire.pc: expected %h, got %h",
                                        halt_pc, last_retire_pc));
            repeat (6) begin                // halted core stays quiet
                step_cycle();
                assert (halt) else fail_run("halt dropped before reset");
                assert (!retire.valid)
                    else fail_run($sformatf("mismatch retire.valid: expected %h, got %h",
                                            1'b0, retire.valid));
            end
        end
        $display("Test OK");
        $finish;
    end

endmodule

/* sim/rv_core_cases.txt */
// per case: word count and store count, program words, then address data mask per store
// all values hex, a count pair of 0 0 ends the file
// case 1: alu register and immediate ops, lui, auipc, back to back dependencies
17 0A
FF800093 00200113 4020D1B3 0020D233 0020A2B3 0020B333 401103B3 12345437
00001497 67846513 00451593 4010D613
04302023 04402223 04502423 04602623 04702823 04802A23 04902C23 04A02E23
06B02023 06C02223 0000007F
00000040 FFFFFFFE F
00000044 3FFFFFFE F
00000048 00000001 F
0000004C 00000000 F
00000050 0000000A F
00000054 12345000 F
00000058 00001020 F
0000005C 12345678 F
00000060 23456780 F
00000064 FFFFFFFC F
// case 2: each branch taken and not taken over a marker store, jal and jalr links
23 08
FFF00093 00100113 05500293
00208463 08502023 00209463 08502223 0020C463 08502423 0020D463 08502623
0020E463 08502823 0020F463 08502A23 00108463 08502C23 00109463 08502E23
00114463 0A502023 00115463 0A502223 00116463 0A502423 00117463 0A502623
0080036F 0A502823 0A602A23 011303E7 0A502C23 0A702E23 0000007F 0C502023
00000080 00000055 F
0000008C 00000055 F
00000090 00000055 F
0000009C 00000055 F
000000A0 00000055 F
000000AC 00000055 F
000000B4 00000070 F
000000BC 0000007C F
// case 3: sb and sh at each offset, then lb lbu lh lhu each used at once by sw
16 0D
876540B7 3A908093 10100023 101000A3 10100123 101001A3 10101223 10101323
10102423 10B00103 10202823 10B04183 10302A23 10A01203 10402C23 10A05283
10502E23 10900303 12602023 10801383 12702223 0000007F
00000100 A9A9A9A9 1
00000101 A9A9A9A9 2
00000102 A9A9A9A9 4
00000103 A9A9A9A9 8
00000104 43A943A9 3
00000106 43A943A9 C
00000108 876543A9 F
00000110 FFFFFF87 F
00000114 00000087 F
00000118 FFFF8765 F
0000011C 00008765 F
00000120 00000043 F
00000124 000043A9 F
0 0

/* sim.f */
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/core_pipe_pkg.sv
verilog/stage_reg.sv
verilog/inst_decode.sv
verilog/inst_execute.sv
verilog/inst_result.sv
verilog/rv_core.sv
sim/rv_core_assert.sv
sim/tb_rv_core.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_rv_core -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/Vtb_rv_core
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi
exit 0
